// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // Bank geometry
    localparam int ADDR_W         = 16;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_SETS       = 32;

    // Byte address split, low to high: byte, word select, set, tag
    localparam int BYTE_BITS = 2;
    localparam int WSEL_BITS = 2;
    localparam int SET_BITS  = 5;
    localparam int TAG_BITS  = ADDR_W - SET_BITS - WSEL_BITS - BYTE_BITS;

    typedef logic [WORD_W-1:0]                word_t;
    typedef word_t [WORDS_PER_LINE-1:0]       line_t;
    typedef logic [TAG_BITS-1:0]              tag_t;
    typedef logic [SET_BITS-1:0]              set_t;
    typedef logic [WSEL_BITS-1:0]             wsel_t;

    // One tag store entry per way and set
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // Request as issued by the core
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        word_t             data;
    } core_req_t;

    // Request after address split, byte offset gone
    typedef struct packed {
        logic  write;
        tag_t  tag;
        set_t  set;
        wsel_t wsel;
        word_t data;
    } req_fields_t;

    typedef struct packed {
        logic  write;
        word_t data;
    } core_rsp_t;

    // Line address is tag and set, data only meaningful on write-back
    typedef struct packed {
        logic  write;
        tag_t  tag;
        set_t  set;
        line_t data;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== cache_bank/cache_sp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_sp_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = cache_pkg::NUM_SETS
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             read,
    input  logic             write,
    input  cache_pkg::set_t  addr,
    input  entry_t           wdata,
    output entry_t           rdata
);

    // Storage array, contents undefined until written
    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read port
    // Write-first on a same-cycle read and write
    // Output holds its value while read is low
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (read) begin
            if (write) begin
                rdata <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== cache_bank/cache_tags.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tags #(
    parameter  int NUM_WAYS = 2,
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 init,
    input  logic                 fill,
    input  logic                 read,
    input  logic                 write,
    input  cache_pkg::set_t      set,
    input  cache_pkg::tag_t      tag,
    input  logic [WAY_BITS-1:0]  evict_way,
    output logic [NUM_WAYS-1:0]  tag_matches,
    output logic                 evict_dirty,
    output cache_pkg::tag_t      evict_tag
);

    import cache_pkg::*;

    // Entries as last read from each way
    tag_entry_t rd_entry [NUM_WAYS];

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        logic       way_en;
        logic       do_write;
        logic       entry_read;
        logic       entry_write;
        tag_entry_t wr_entry;

        // Victim way only, or the only way there is
        assign way_en = (NUM_WAYS == 1) || (evict_way == WAY_BITS'(i));

        // Store hit marks only the way that matched
        assign do_write = write && tag_matches[i];

        // Refresh the read port on updates so tag_matches tracks the store
        assign entry_read  = read || write || fill;
        assign entry_write = init || (fill && way_en) || do_write;

        // Init writes an invalid entry
        // A store miss fill comes in already dirty
        assign wr_entry = '{valid: fill || write, dirty: write, tag: tag};

        cache_sp_ram #(
            .entry_t (tag_entry_t),
            .DEPTH   (NUM_SETS)
        ) tag_ram (
            .clk   (clk),
            .rst   (rst),
            .read  (entry_read),
            .write (entry_write),
            .addr  (set),
            .wdata (wr_entry),
            .rdata (rd_entry[i])
        );

        // Parallel compare against the request tag
        assign tag_matches[i] = rd_entry[i].valid && (rd_entry[i].tag == tag);
    end

    // Victim info for write-back
    assign evict_dirty = rd_entry[evict_way].valid && rd_entry[evict_way].dirty;
    assign evict_tag   = rd_entry[evict_way].tag;

endmodule

`default_nettype wire

// ==== cache_bank/cache_bank_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_bank_exec #(
    parameter  int NUM_WAYS = 2,
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    s1_valid,
    input  cache_pkg::req_fields_t  s1_req,
    input  cache_pkg::set_t         rd_set,
    input  logic                    rd_en,
    output logic                    hold,
    output logic                    busy,
    output logic                    mem_req_valid,
    output cache_pkg::mem_req_t     mem_req,
    input  logic                    mem_rsp_valid,
    input  cache_pkg::line_t        mem_rsp_data,
    output logic                    rsp_en,
    output cache_pkg::line_t        rsp_line,
    output cache_pkg::wsel_t        rsp_wsel,
    output logic                    rsp_write
);

    import cache_pkg::*;

    typedef enum logic [2:0] {
        S_INIT,
        S_RUN,
        S_WB,
        S_FILL_WAIT,
        S_FILL_WRITE
    } state_t;

    state_t              state;
    state_t              state_n;
    set_t                init_cnt;
    logic [WAY_BITS-1:0] victim_way;
    logic [NUM_WAYS-1:0] tag_matches;
    logic                evict_dirty;
    tag_t                evict_tag;
    line_t               data_rdata [NUM_WAYS];
    set_t                ram_set;
    logic                decide;
    logic                hit;
    logic                miss;
    logic                wb_start;
    logic                store_hit;
    logic                fill_done;
    line_t               hit_line;
    line_t               victim_line;
    line_t               store_line;
    line_t               fill_line;

    // Put the store word into its slot of a line
    function automatic line_t merge_word(line_t line, req_fields_t req);
        line_t merged;
        merged = line;
        if (req.write) begin
            merged[req.wsel] = req.data;
        end
        return merged;
    endfunction

    // Decide cycle is the one after acceptance
    assign decide    = (state == S_RUN) && s1_valid;
    assign hit       = |tag_matches;
    assign miss      = decide && !hit;
    assign wb_start  = miss && evict_dirty;
    assign store_hit = decide && hit && s1_req.write;
    assign fill_done = (state == S_FILL_WAIT) && mem_rsp_valid;

    // Set from the init sweep, a new request or the stage-one request
    assign ram_set = (state == S_INIT) ? init_cnt : (rd_en ? rd_set : s1_req.set);

    assign busy = (state != S_RUN) || (s1_valid && (!hit || s1_req.write));
    assign hold = miss || (state == S_WB) || (state == S_FILL_WAIT);

    cache_tags #(
        .NUM_WAYS (NUM_WAYS)
    ) tags (
        .clk         (clk),
        .rst         (rst),
        .init        (state == S_INIT),
        .fill        (fill_done),
        .read        (rd_en),
        .write       (store_hit || (fill_done && s1_req.write)),
        .set         (ram_set),
        .tag         (s1_req.tag),
        .evict_way   (victim_way),
        .tag_matches (tag_matches),
        .evict_dirty (evict_dirty),
        .evict_tag   (evict_tag)
    );

    // Hit line from the matching way and victim line from the pointer
    always_comb begin
        hit_line    = '0;
        victim_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (tag_matches[w]) begin
                hit_line = hit_line | data_rdata[w];
            end
            if (victim_way == WAY_BITS'(w)) begin
                victim_line = data_rdata[w];
            end
        end
    end

    assign store_line = merge_word(hit_line, s1_req);
    assign fill_line  = merge_word(mem_rsp_data, s1_req);

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_data
        logic  way_sel;
        logic  data_write;
        line_t data_wdata;

        assign way_sel    = (NUM_WAYS == 1) || (victim_way == WAY_BITS'(w));
        assign data_write = (store_hit && tag_matches[w]) || (fill_done && way_sel);
        assign data_wdata = fill_done ? fill_line : store_line;

        // Read on fill too so the new line shows up for the response
        cache_sp_ram #(
            .entry_t (line_t),
            .DEPTH   (NUM_SETS)
        ) data_ram (
            .clk   (clk),
            .rst   (rst),
            .read  (rd_en || fill_done),
            .write (data_write),
            .addr  (ram_set),
            .wdata (data_wdata),
            .rdata (data_rdata[w])
        );
    end

    // Response on a hit or in the cycle after the fill write
    // Store line equals the hit line on a load
    assign rsp_en    = (decide && hit) || (state == S_FILL_WRITE);
    assign rsp_line  = (state == S_FILL_WRITE) ? victim_line : store_line;
    assign rsp_wsel  = s1_req.wsel;
    assign rsp_write = s1_req.write;

    always_comb begin
        state_n = state;
        case (state)
            S_INIT: begin
                if (init_cnt == set_t'(NUM_SETS - 1)) begin
                    state_n = S_RUN;
                end
            end
            S_RUN: begin
                if (miss) begin
                    state_n = evict_dirty ? S_WB : S_FILL_WAIT;
                end
            end
            // Write-back strobe is out and the fill read goes next
            S_WB:         state_n = S_FILL_WAIT;
            S_FILL_WAIT: begin
                if (mem_rsp_valid) begin
                    state_n = S_FILL_WRITE;
                end
            end
            S_FILL_WRITE: state_n = S_RUN;
            default:      state_n = S_INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_INIT;
            init_cnt   <= '0;
            victim_way <= '0;
        end else begin
            state <= state_n;
            if (state == S_INIT) begin
                init_cnt <= init_cnt + 1'b1;
            end
            // Round-robin pointer moves once per fill
            if (state == S_FILL_WRITE) begin
                if (victim_way == WAY_BITS'(NUM_WAYS - 1)) begin
                    victim_way <= '0;
                end else begin
                    victim_way <= victim_way + 1'b1;
                end
            end
        end
    end

    // Memory strobe carries the victim write on a dirty miss and the fill read otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= miss || (state == S_WB);
        end
    end

    always_ff @(posedge clk) begin
        mem_req.write <= wb_start;
        mem_req.tag   <= wb_start ? evict_tag : s1_req.tag;
        mem_req.set   <= s1_req.set;
        mem_req.data  <= victim_line;
    end

endmodule

`default_nettype wire

// ==== hdl/cache_req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_req_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    core_req_valid,
    input  cache_pkg::core_req_t    core_req,
    input  logic                    busy,
    input  logic                    hold,
    output logic                    rd_en,
    output cache_pkg::set_t         rd_set,
    output logic                    s1_valid,
    output cache_pkg::req_fields_t  s1_req
);

    import cache_pkg::*;

    // Field positions in the byte address
    localparam int WSEL_LSB = BYTE_BITS;
    localparam int SET_LSB  = WSEL_LSB + WSEL_BITS;
    localparam int TAG_LSB  = SET_LSB + SET_BITS;

    req_fields_t req_dec;

    // Taken only while the bank is idle enough
    assign rd_en = core_req_valid && !busy;

    // Byte offset is dropped
    assign req_dec = '{
        write: core_req.write,
        tag:   core_req.addr[TAG_LSB +: TAG_BITS],
        set:   core_req.addr[SET_LSB +: SET_BITS],
        wsel:  core_req.addr[WSEL_LSB +: WSEL_BITS],
        data:  core_req.data
    };

    // Set goes straight to the RAMs for the read at acceptance
    assign rd_set = req_dec.set;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (!hold) begin
            s1_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            s1_req <= req_dec;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cache_rsp.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_rsp (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rsp_en,
    input  cache_pkg::line_t      rsp_line,
    input  cache_pkg::wsel_t      rsp_wsel,
    input  logic                  rsp_write,
    output logic                  core_rsp_valid,
    output cache_pkg::core_rsp_t  core_rsp
);

    import cache_pkg::*;

    word_t sel_word;

    // Word select out of the line
    assign sel_word = rsp_line[rsp_wsel];

    // One-cycle strobe per response
    always_ff @(posedge clk) begin
        if (rst) begin
            core_rsp_valid <= 1'b0;
        end else begin
            core_rsp_valid <= rsp_en;
        end
    end

    // Payload only loads with a response
    always_ff @(posedge clk) begin
        if (rsp_en) begin
            core_rsp.write <= rsp_write;
            core_rsp.data  <= sel_word;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cache_bank_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_bank_top #(
    parameter int NUM_WAYS = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  core_req_valid,
    input  cache_pkg::core_req_t  core_req,
    output logic                  busy,
    output logic                  core_rsp_valid,
    output cache_pkg::core_rsp_t  core_rsp,
    output logic                  mem_req_valid,
    output cache_pkg::mem_req_t   mem_req,
    input  logic                  mem_rsp_valid,
    input  cache_pkg::line_t      mem_rsp_data
);

    import cache_pkg::*;

    // Decode to execute
    logic        rd_en;
    set_t        rd_set;
    logic        s1_valid;
    req_fields_t s1_req;
    logic        hold;

    // Execute to result
    logic        rsp_en;
    line_t       rsp_line;
    wsel_t       rsp_wsel;
    logic        rsp_write;

    cache_req_decode decode (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .busy           (busy),
        .hold           (hold),
        .rd_en          (rd_en),
        .rd_set         (rd_set),
        .s1_valid       (s1_valid),
        .s1_req         (s1_req)
    );

    cache_bank_exec #(
        .NUM_WAYS (NUM_WAYS)
    ) exec (
        .clk           (clk),
        .rst           (rst),
        .s1_valid      (s1_valid),
        .s1_req        (s1_req),
        .rd_set        (rd_set),
        .rd_en         (rd_en),
        .hold          (hold),
        .busy          (busy),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .rsp_en        (rsp_en),
        .rsp_line      (rsp_line),
        .rsp_wsel      (rsp_wsel),
        .rsp_write     (rsp_write)
    );

    cache_rsp result (
        .clk            (clk),
        .rst            (rst),
        .rsp_en         (rsp_en),
        .rsp_line       (rsp_line),
        .rsp_wsel       (rsp_wsel),
        .rsp_write      (rsp_write),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp)
    );

endmodule

`default_nettype wire

// ==== sim/cache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 busy,
    input logic                 core_rsp_valid,
    input logic                 mem_req_valid,
    input cache_pkg::mem_req_t  mem_req
);

    // Only a victim write may be followed at once by another strobe
    a_mem_strobe_spacing: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req.write) |=> !mem_req_valid)
        else $error("memory read strobe held for two cycles");

    // No response straight out of reset
    a_no_rsp_after_rst: assert property (@(posedge clk)
        rst |=> !core_rsp_valid)
        else $error("core response right after reset");

    // Init sweep owns the bank once reset drops
    a_busy_after_rst: assert property (@(posedge clk)
        $fell(rst) |-> busy)
        else $error("busy low in the first cycle after reset");

endmodule

bind cache_bank_top cache_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .busy           (busy),
    .core_rsp_valid (core_rsp_valid),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req)
);

`default_nettype wire

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    import cache_pkg::*;

    typedef logic [TAG_BITS+SET_BITS-1:0] laddr_t;

    localparam int NUM_WAYS    = 2;
    localparam int CLK_PERIOD  = 20;
    localparam int MEM_LATENCY = 3;
    // Response is set by the edge right after the accepting one
    localparam int HIT_LATENCY = 1;
    // Decide, write-back, fill read, memory wait, fill write, response, with slack
    localparam int MISS_CYCLES = 14;
    localparam int RAND_OPS    = 200;
    localparam int TOTAL_OPS   = RAND_OPS + 20;
    localparam int WAIT_LIMIT  = NUM_SETS + MISS_CYCLES;
    localparam int WATCHDOG_NS = (NUM_SETS + TOTAL_OPS * MISS_CYCLES + 200) * CLK_PERIOD;

    logic      clk;
    logic      rst;
    logic      core_req_valid;
    core_req_t core_req;
    logic      busy;
    logic      core_rsp_valid;
    core_rsp_t core_rsp;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_rsp_valid;
    line_t     mem_rsp_data;

    int        errors;
    int        cyc;
    int        acc_cyc;
    int        seed;

    // Memory model, indexed by line address
    line_t     mem_lines [1 << (TAG_BITS + SET_BITS)];
    bit        mem_written [1 << (TAG_BITS + SET_BITS)];
    int        mem_rd_cnt;
    int        mem_wr_cnt;
    laddr_t    last_rd_addr;
    laddr_t    last_wb_addr;
    line_t     last_wb_line;
    int        rd_due_q[$];
    laddr_t    rd_addr_q[$];

    // Reference model, one word per word address
    word_t     ref_mem [1 << (ADDR_W - BYTE_BITS)];

    // Responses as seen on the core side
    core_rsp_t rsp_q[$];
    int        rsp_cyc_q[$];

    cache_bank_top #(
        .NUM_WAYS (NUM_WAYS)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .busy           (busy),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Unwritten memory: line address in the upper half, word index below
    function automatic word_t init_word(input laddr_t la, input int idx);
        return {16'(la), 16'(idx)};
    endfunction

    function automatic line_t read_line(input laddr_t la);
        line_t line;
        int    w;
        if (mem_written[la]) begin
            line = mem_lines[la];
        end else begin
            for (w = 0; w < WORDS_PER_LINE; w++) begin
                line[w] = init_word(la, w);
            end
        end
        return line;
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input int wsel);
        return {tag_t'(tag), set_t'(set), wsel_t'(wsel), 2'b00};
    endfunction

    // Strobes sampled mid-cycle, writes land at once
    always @(negedge clk) begin
        if (mem_req_valid) begin
            if (mem_req.write) begin
                mem_lines[{mem_req.tag, mem_req.set}]   = mem_req.data;
                mem_written[{mem_req.tag, mem_req.set}] = 1'b1;
                last_wb_addr = {mem_req.tag, mem_req.set};
                last_wb_line = mem_req.data;
                mem_wr_cnt++;
            end else begin
                rd_addr_q.push_back({mem_req.tag, mem_req.set});
                rd_due_q.push_back(cyc + MEM_LATENCY);
                last_rd_addr = {mem_req.tag, mem_req.set};
                mem_rd_cnt++;
            end
        end
    end

    // Read answer, one strobe carrying the whole line
    always @(posedge clk) begin
        #2;
        mem_rsp_valid = 1'b0;
        if (rd_due_q.size() > 0 && rd_due_q[0] == cyc) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = read_line(rd_addr_q[0]);
            rd_due_q.delete(0);
            rd_addr_q.delete(0);
        end
    end

    always @(negedge clk) begin
        if (core_rsp_valid) begin
            rsp_q.push_back(core_rsp);
            rsp_cyc_q.push_back(cyc);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail %s: expected %08h, actual %08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input bit ok, input string what);
        assert (ok) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    // Offer a request, return just after the edge that took it
    task automatic send_req(input logic wr, input logic [ADDR_W-1:0] addr, input word_t data);
        int n;
        core_req_valid = 1'b1;
        core_req.write = wr;
        core_req.addr  = addr;
        core_req.data  = data;
        n = 0;
        @(negedge clk);
        while (busy && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        check_true(!busy, $sformatf("request to address %04h was never accepted", addr));
        @(posedge clk);
        #2;
        acc_cyc        = cyc;
        core_req_valid = 1'b0;
    endtask

    task automatic wait_rsp(input string name, output core_rsp_t rsp, output int rsp_cyc);
        int n;
        n = 0;
        while (rsp_q.size() == 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (rsp_q.size() == 0) begin
            check_true(1'b0, $sformatf("%s got no response from the bank", name));
            rsp     = '0;
            rsp_cyc = -1;
        end else begin
            rsp     = rsp_q.pop_front();
            rsp_cyc = rsp_cyc_q.pop_front();
        end
    endtask

    task automatic do_read(input string name, input logic [ADDR_W-1:0] addr, output int lat);
        core_rsp_t rsp;
        int        rsp_cyc;
        send_req(1'b0, addr, '0);
        wait_rsp(name, rsp, rsp_cyc);
        lat = rsp_cyc - acc_cyc;
        check_value(name, ref_mem[addr[ADDR_W-1:BYTE_BITS]], rsp.data);
        check_value({name, "_flag"}, 0, rsp.write);
    endtask

    task automatic do_write(input string name, input logic [ADDR_W-1:0] addr, input word_t data);
        core_rsp_t rsp;
        int        rsp_cyc;
        ref_mem[addr[ADDR_W-1:BYTE_BITS]] = data;
        send_req(1'b1, addr, data);
        wait_rsp(name, rsp, rsp_cyc);
        check_value({name, "_flag"}, 1, rsp.write);
    endtask

    task automatic test_init();
        int n;
        int lat;
        int rd0;
        int wr0;
        n = 0;
        @(negedge clk);
        while (busy && n < NUM_SETS + 4) begin
            n++;
            @(negedge clk);
        end
        check_true(!busy, "busy still high long after the init sweep");
        @(posedge clk);
        #2;
        rd0 = mem_rd_cnt;
        wr0 = mem_wr_cnt;
        do_read("init_read", make_addr(1, 0, 0), lat);
        check_value("init_fill_reads", rd0 + 1, mem_rd_cnt);
        check_value("init_writebacks", wr0, mem_wr_cnt);
        check_value("init_fill_addr", {tag_t'(1), set_t'(0)}, last_rd_addr);
    endtask

    task automatic test_read_hit();
        int lat;
        int rd0;
        int wr0;
        do_read("read_miss", make_addr(1, 1, 2), lat);
        rd0 = mem_rd_cnt;
        wr0 = mem_wr_cnt;
        do_read("read_hit", make_addr(1, 1, 3), lat);
        check_value("read_hit_latency", HIT_LATENCY, lat);
        check_value("read_hit_mem_reads", rd0, mem_rd_cnt);
        check_value("read_hit_mem_writes", wr0, mem_wr_cnt);
    endtask

    task automatic test_write_hit();
        int lat;
        int rd0;
        int wr0;
        rd0 = mem_rd_cnt;
        wr0 = mem_wr_cnt;
        do_write("write_hit", make_addr(1, 1, 0), 32'h1234_abcd);
        do_read("write_readback", make_addr(1, 1, 0), lat);
        check_value("write_hit_mem_reads", rd0, mem_rd_cnt);
        check_value("write_hit_mem_writes", wr0, mem_wr_cnt);
    endtask

    // Dirty line in a fresh set, then enough reads to cycle the victim pointer back
    task automatic test_dirty_evict();
        int i;
        int w;
        int lat;
        int wr0;
        do_write("evict_store", make_addr(2, 5, 1), 32'hc0de_0005);
        wr0 = mem_wr_cnt;
        for (i = 1; i <= NUM_WAYS; i++) begin
            do_read("evict_read", make_addr(2 + i, 5, 0), lat);
        end
        check_value("evict_writebacks", wr0 + 1, mem_wr_cnt);
        check_value("evict_wb_addr", {tag_t'(2), set_t'(5)}, last_wb_addr);
        for (w = 0; w < WORDS_PER_LINE; w++) begin
            check_value("evict_wb_word", ref_mem[{tag_t'(2), set_t'(5), wsel_t'(w)}],
                        last_wb_line[w]);
        end
    endtask

    task automatic test_back_to_back();
        logic [ADDR_W-1:0] addrs [4];
        core_rsp_t         rsp;
        int                rsp_cyc;
        int                prev;
        int                lat;
        int                rd0;
        int                i;
        addrs[0] = make_addr(5, 9, 1);
        addrs[1] = make_addr(6, 10, 2);
        addrs[2] = make_addr(5, 9, 3);
        addrs[3] = make_addr(6, 10, 1);
        // Bring both lines in first
        do_read("b2b_warm_x", make_addr(5, 9, 0), lat);
        do_read("b2b_warm_y", make_addr(6, 10, 0), lat);
        rd0  = mem_rd_cnt;
        prev = 0;
        for (i = 0; i < 4; i++) begin
            send_req(1'b0, addrs[i], '0);
            if (i > 0) begin
                check_value("b2b_accept_cycle", prev + 1, acc_cyc);
            end
            prev = acc_cyc;
        end
        for (i = 0; i < 4; i++) begin
            wait_rsp("b2b_read", rsp, rsp_cyc);
            check_value("b2b_read", ref_mem[addrs[i][ADDR_W-1:BYTE_BITS]], rsp.data);
        end
        check_value("b2b_mem_reads", rd0, mem_rd_cnt);
    endtask

    // Few sets, many tags, so evictions and write-backs keep happening
    task automatic test_random();
        logic [31:0]       r;
        word_t             data;
        logic [ADDR_W-1:0] addr;
        int                i;
        int                lat;
        for (i = 0; i < RAND_OPS; i++) begin
            r    = $random(seed);
            data = $random(seed);
            addr = make_addr(int'(r[6:4]), 12 + int'(r[2:1]), int'(r[9:8]));
            if (r[0]) begin
                do_write($sformatf("random_write_%0d", i), addr, data);
            end else begin
                do_read($sformatf("random_read_%0d", i), addr, lat);
            end
        end
    endtask

    initial begin
        int a;
        errors         = 0;
        cyc            = 0;
        acc_cyc        = 0;
        seed           = 32'h8378_dfc6;
        mem_rd_cnt     = 0;
        mem_wr_cnt     = 0;
        last_rd_addr   = '0;
        last_wb_addr   = '0;
        last_wb_line   = '0;
        rst            = 1'b1;
        core_req_valid = 1'b0;
        core_req       = '0;
        mem_rsp_valid  = 1'b0;
        mem_rsp_data   = '0;
        for (a = 0; a < (1 << (TAG_BITS + SET_BITS)); a++) begin
            mem_written[a] = 1'b0;
        end
        for (a = 0; a < (1 << (ADDR_W - BYTE_BITS)); a++) begin
            ref_mem[a] = init_word(laddr_t'(a >> 2), a % WORDS_PER_LINE);
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        test_init();
        test_read_hit();
        test_write_hit();
        test_dirty_evict();
        test_back_to_back();
        test_random();
        $display("Finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
common/cache_pkg.sv
cache_bank/cache_sp_ram.sv
cache_bank/cache_tags.sv
cache_bank/cache_bank_exec.sv
hdl/cache_req_decode.sv
hdl/cache_rsp.sv
hdl/cache_bank_top.sv
sim/cache_checker.sv
sim/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cache bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_tb \
    -f all.f \
    -o sim_cache_tb

./obj_dir/sim_cache_tb | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
